//--- sources.f
+incdir+include
logic/fpu_exp_pkg.sv
logic/fpu_pipe_pkg.sv
logic/exp_stage_if.sv
logic/exp_compare.sv
logic/exp_adjust.sv
logic/exp_result.sv
logic/fpu_add_exp.sv
testbench/tb_fpu_add_exp.sv

//--- Makefile
# Verilator build and run of the add exponent testbench
# every variable below can be overridden on the command line

SHELL     := /bin/bash

VERILATOR ?= verilator
TOP       ?= tb_fpu_add_exp
RTL_TOP   ?= fpu_add_exp
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?=
FAIL_MSG  ?= ERRORS FOUND

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary --timing --assert --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -f $(FILELIST) $(VFLAGS)

run: build
	set -o pipefail; ./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- testbench/tb_fpu_add_exp.sv
//////////////////////////////////////////////////////////////////////
// testbench of the add pipe exponent datapath
// LFSR stimulus against a stage model, run with the Makefile
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_fpu_add_exp;

	localparam int PERIOD_NS    = 100;
	localparam int RESET_CYCLES = 16;
	localparam int N_COMPARE    = 64;  // per precision
	localparam int N_STREAM     = 128;
	localparam int N_HOLD       = 96;  // up to 3 stall cycles after each
	localparam int N_NORM       = 128;
	localparam int N_DIRECTED   = 6;   // 6 edges each
	localparam int DRAIN        = 6;
	localparam int TOTAL_CYCLES = RESET_CYCLES + 2 * N_COMPARE + N_STREAM
		+ 4 * N_HOLD + N_NORM + 6 * N_DIRECTED + DRAIN;
	localparam int WATCHDOG_NS  = (TOTAL_CYCLES + 100) * PERIOD_NS;
	localparam int MODE_PLAIN   = 0;   // adjust code only
	localparam int MODE_NORM    = 1;   // shift count and round carry too

	// normalize adjust codes
	localparam logic [1:0] ADJ_SAME = 2'd0;
	localparam logic [1:0] ADJ_INC  = 2'd1;
	localparam logic [1:0] ADJ_DEC  = 2'd2;

	typedef struct packed {
		logic [10:0] in1;
		logic [10:0] in2;
		logic        dbl;
		logic [1:0]  adj;   // used in stage 3
		logic [5:0]  shl;   // used in stage 4
		logic        cout;
		int          exp;   // model exponent, can go negative
	} item_t;

	logic        rclk = 1'b0;
	logic        arst_n = 1'b0;
	logic        a1_step = 1'b0;
	logic        a6_step = 1'b0;
	logic [10:0] in1_exp = '0;
	logic [10:0] in2_exp = '0;
	logic        dblop = 1'b0;
	logic [1:0]  a3_adj = '0;
	logic [5:0]  shl_cnt = '0;
	logic        rnd_cout = 1'b0;
	wire  [11:0] o_exp_diff;
	wire         o_in2_larger;
	wire  [11:0] o_a4stg_exp;
	wire  [10:0] o_add_exp_out;

	logic [31:0] lfsr = 32'h9284;
	item_t       pipe_q[$];   // stages 2, 3, 4
	item_t       s1_item;     // stage 1 operands
	item_t       drv_item;    // what sits on the input pins
	int          out_model;
	logic        edge_step;   // step value at the last edge
	logic [10:0] last_out;
	string       test_name = "reset";
	int          checks;
	int          value_errors;
	int          hold_errors;

	always #(PERIOD_NS / 2) rclk = ~rclk;

	fpu_add_exp dut0 (
		.rclk                (rclk),
		.i_arst_n            (arst_n),
		.i_a1stg_step        (a1_step),
		.i_a6stg_step        (a6_step),
		.i_in1_exp           (in1_exp),
		.i_in2_exp           (in2_exp),
		.i_dblop             (dblop),
		.i_a3stg_adj         (a3_adj),
		.i_a4stg_shl_cnt     (shl_cnt),
		.i_a4stg_rndadd_cout (rnd_cout),
		.o_exp_diff          (o_exp_diff),
		.o_in2_larger        (o_in2_larger),
		.o_a4stg_exp         (o_a4stg_exp),
		.o_add_exp_out       (o_add_exp_out)
	);

	// stalled pipe keeps stage 4
	assert property (@(posedge rclk) disable iff (!arst_n) !a6_step |=> $stable(o_a4stg_exp))
		else begin
			hold_errors++;
			$display("stage 4 exponent changed while i_a6stg_step was low at %0t", $time);
		end

	//////////////////////////////////////////////////////////////////////
	// random source and reference rules
	//////////////////////////////////////////////////////////////////////

	function automatic logic lfsr_bit();
		logic b;
		b = lfsr[0];
		lfsr = lfsr >> 1;
		if (b) lfsr = lfsr ^ 32'h8020_0003; // x^32 + x^22 + x^2 + x + 1
		return b;
	endfunction

	function automatic int rand_bits(input int n);
		int v;
		v = 0;
		for (int i = 0; i < n; i++) v = (v << 1) | int'(lfsr_bit());
		return v;
	endfunction

	function automatic int field_of(input logic [10:0] raw, input logic dbl);
		return dbl ? int'(raw) : int'(raw >> 3); // single uses the top 8 bits
	endfunction

	function automatic int larger_of(input item_t it);
		int f1;
		int f2;
		f1 = field_of(it.in1, it.dbl);
		f2 = field_of(it.in2, it.dbl);
		return (f2 > f1) ? f2 : f1;
	endfunction

	function automatic int adjust_of(input int e, input logic [1:0] adj);
		if (adj == ADJ_INC) return e + 1;
		if (adj == ADJ_DEC) return e - 1;
		return e;
	endfunction

	function automatic int result_of(input item_t it);
		int v;
		int mx;
		mx = it.dbl ? 'h7ff : 'hff;
		if (it.shl != 0) v = it.exp - int'(it.shl);
		else if (it.cout) v = it.exp + 1;
		else v = it.exp;
		if (v < 0) return 0;      // underflow
		if (v >= mx) return mx;   // saturate
		return v;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// drive, model and check one clock
	//////////////////////////////////////////////////////////////////////

	task automatic check_val(input string what, input int expv, input int actv);
		checks++;
		assert (expv == actv) else begin
			value_errors++;
			$display("FAILED %s %s: expected %0h, actual %0h", test_name, what, expv, actv);
		end
	endtask

	task automatic compare_outputs();
		int d;
		d = field_of(s1_item.in1, s1_item.dbl) - field_of(s1_item.in2, s1_item.dbl);
		check_val("exp_diff", d & 'hfff, int'(o_exp_diff));
		check_val("in2_larger", (d < 0) ? 1 : 0, int'(o_in2_larger));
		check_val("a4stg_exp", pipe_q[2].exp & 'hfff, int'(o_a4stg_exp));
		check_val("add_exp_out", out_model, int'(o_add_exp_out));
		if (!edge_step) begin
			assert (o_add_exp_out == last_out) else begin
				hold_errors++;
				$display("FAILED %s hold: expected %0h, actual %0h", test_name, last_out,
					o_add_exp_out);
			end
		end
		last_out = o_add_exp_out;
	endtask

	task automatic clock_edge(input logic ld, input logic st, input item_t nxt);
		item_t new2;
		item_t new4;
		@(posedge rclk);
		edge_step = a6_step;              // pins as the DUT samples them
		if (a6_step) begin
			out_model = result_of(pipe_q[2]);
			new4 = pipe_q[1];
			new4.exp = adjust_of(new4.exp, new4.adj);
			new2 = s1_item;
			new2.exp = larger_of(s1_item);
			void'(pipe_q.pop_back());
			pipe_q[1] = new4;
			pipe_q.push_front(new2);
		end
		if (a1_step) s1_item = drv_item;  // after the shift, old stage 1 moved on
		a1_step <= ld;
		a6_step <= st;
		if (ld) begin
			drv_item = nxt;
			in1_exp <= nxt.in1;
			in2_exp <= nxt.in2;
			dblop <= nxt.dbl;
		end
		a3_adj <= pipe_q[1].adj;          // controls follow the item in their stage
		shl_cnt <= pipe_q[2].shl;
		rnd_cout <= pipe_q[2].cout;
		@(negedge rclk);
		compare_outputs();
	endtask

	//////////////////////////////////////////////////////////////////////
	// test sequences
	//////////////////////////////////////////////////////////////////////

	task automatic make_item(input int mode, input int dbl_sel, output item_t it);
		it = '0;
		it.dbl = (dbl_sel == 2) ? lfsr_bit() : dbl_sel[0];
		if (mode == MODE_NORM && lfsr_bit()) begin
			it.in1 = 11'(rand_bits(7)); // small exponents reach underflow
			it.in2 = 11'(rand_bits(7));
		end else begin
			it.in1 = 11'(rand_bits(11));
			it.in2 = 11'(rand_bits(11));
		end
		it.adj = 2'(rand_bits(2));
		if (mode == MODE_NORM) begin
			if (lfsr_bit()) it.shl = 6'(rand_bits(6));
			it.cout = lfsr_bit();
		end
	endtask

	task automatic run_items(input int n, input int dbl_sel, input int mode, input bit gaps);
		item_t it;
		int    gap;
		for (int i = 0; i < n; i++) begin
			make_item(mode, dbl_sel, it);
			clock_edge(1'b1, 1'b1, it);
			gap = gaps ? rand_bits(2) : 0;
			for (int g = 0; g < gap; g++) clock_edge(1'b0, 1'b0, it);
		end
	endtask

	task automatic directed_case(input string name, input logic [10:0] in1,
		input logic [10:0] in2, input logic dbl, input logic [1:0] adj,
		input logic [5:0] shl, input logic cout, input int expv);
		item_t it;
		it = '0;
		it.in1 = in1;
		it.in2 = in2;
		it.dbl = dbl;
		it.adj = adj;
		it.shl = shl;
		it.cout = cout;
		test_name = name;
		clock_edge(1'b1, 1'b1, it);
		repeat (5) clock_edge(1'b0, 1'b1, it); // load edge plus four
		check_val("directed result", expv, int'(o_add_exp_out));
	endtask

	initial begin
		item_t blank;
		blank = '0;
		repeat (3) pipe_q.push_back(blank);
		s1_item = blank;
		drv_item = blank;
		out_model = 0;
		edge_step = 1'b0;
		repeat (RESET_CYCLES) @(posedge rclk);
		arst_n <= 1'b1;
		@(negedge rclk);
		check_val("add_exp_out", 0, int'(o_add_exp_out));
		check_val("a4stg_exp", 0, int'(o_a4stg_exp));
		check_val("in2_larger", 0, int'(o_in2_larger));
		last_out = o_add_exp_out;
		test_name = "compare double";
		run_items(N_COMPARE, 1, MODE_PLAIN, 1'b0);
		test_name = "compare single";
		run_items(N_COMPARE, 0, MODE_PLAIN, 1'b0);
		test_name = "streaming";
		run_items(N_STREAM, 2, MODE_PLAIN, 1'b0);
		test_name = "hold";
		run_items(N_HOLD, 2, MODE_NORM, 1'b1);
		test_name = "normalize";
		run_items(N_NORM, 2, MODE_NORM, 1'b0);
		directed_case("overflow double", 11'h7fe, 11'h000, 1'b1, ADJ_INC, 6'd0, 1'b1, 'h7ff);
		directed_case("overflow single", 11'h7f0, 11'h000, 1'b0, ADJ_INC, 6'd0, 1'b1, 'h0ff);
		directed_case("shift subtract", 11'h400, 11'h123, 1'b1, ADJ_SAME, 6'h10, 1'b0, 'h3f0);
		directed_case("shift underflow", 11'h003, 11'h001, 1'b1, ADJ_SAME, 6'd5, 1'b0, 0);
		directed_case("round carry", 11'h123, 11'h000, 1'b1, ADJ_SAME, 6'd0, 1'b1, 'h124);
		directed_case("in2 larger dec", 11'h010, 11'h300, 1'b1, ADJ_DEC, 6'd0, 1'b0, 'h2ff);
		test_name = "drain";
		repeat (DRAIN) clock_edge(1'b0, 1'b1, blank);
		$display("checks: %0d, value errors: %0d, hold errors: %0d", checks, value_errors,
			hold_errors);
		if (value_errors + hold_errors == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

	// bound on the whole sequence
	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired at %0t, the test sequence did not finish", $time);
		$display("ERRORS FOUND");
		$finish;
	end

endmodule

`default_nettype wire

//--- logic/fpu_add_exp.sv
//////////////////////////////////////////////////////////////////////
// add pipe exponent datapath top
// wires compare, adjust and result stages to the plain port list
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "fpu_exp_config.svh"

module fpu_add_exp import fpu_exp_pkg::*, fpu_pipe_pkg::*; (
	input  wire            rclk,                // pipe clock
	input  wire            i_arst_n,
	input  wire            i_a1stg_step,        // load stage 1
	input  wire            i_a6stg_step,        // advance the pipe
	input  wire exp_t      i_in1_exp,
	input  wire exp_t      i_in2_exp,
	input  wire            i_dblop,             // 1 = double, 0 = single
	input  wire exp_adj_t  i_a3stg_adj,         // valid while item is in stage 3
	input  wire shl_cnt_t  i_a4stg_shl_cnt,     // valid while item is in stage 4
	input  wire            i_a4stg_rndadd_cout, // valid while item is in stage 4
	output exp_diff_t      o_exp_diff,
	output logic           o_in2_larger,
	output exp_diff_t      o_a4stg_exp,         // stage 4 exponent, low bits
	output exp_t           o_add_exp_out
);

	exp_stage_if stg_if ();   // stage 2 boundary

	exp_wide_t a4_exp;        // full stage 4 exponent
	logic      a4_dbl;

	exp_compare u_compare (
		.i_rclk       (rclk),
		.i_arst_n     (i_arst_n),
		.i_a1stg_step (i_a1stg_step),
		.i_a6stg_step (i_a6stg_step),
		.i_in1_exp    (i_in1_exp),
		.i_in2_exp    (i_in2_exp),
		.i_dblop      (i_dblop),
		.o_exp_diff   (o_exp_diff),
		.o_in2_larger (o_in2_larger),
		.o_stg        (stg_if.src)
	);

	exp_adjust u_adjust (
		.i_rclk       (rclk),
		.i_arst_n     (i_arst_n),
		.i_a6stg_step (i_a6stg_step),
		.i_a3stg_adj  (i_a3stg_adj),
		.i_stg        (stg_if.dst),
		.o_a4stg_exp  (a4_exp),
		.o_a4stg_dbl  (a4_dbl)
	);

	exp_result u_result (
		.i_rclk              (rclk),
		.i_arst_n            (i_arst_n),
		.i_a6stg_step        (i_a6stg_step),
		.i_a4stg_exp         (a4_exp),
		.i_a4stg_dbl         (a4_dbl),
		.i_a4stg_shl_cnt     (i_a4stg_shl_cnt),
		.i_a4stg_rndadd_cout (i_a4stg_rndadd_cout),
		.o_add_exp_out       (o_add_exp_out)
	);

	assign o_a4stg_exp = a4_exp[`FPU_DIFF_W-1:0]; // guard bit stays inside

endmodule

`default_nettype wire

//--- logic/exp_result.sv
//////////////////////////////////////////////////////////////////////
// stage 4 output of the exponent path
// shift count subtract, round increment, clamp and result register
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "fpu_exp_config.svh"

module exp_result import fpu_exp_pkg::*, fpu_pipe_pkg::*; (
	input  wire            i_rclk,
	input  wire            i_arst_n,
	input  wire            i_a6stg_step,        // load the output register
	input  wire exp_wide_t i_a4stg_exp,         // stage 4 exponent
	input  wire            i_a4stg_dbl,         // stage 4 precision
	input  wire shl_cnt_t  i_a4stg_shl_cnt,     // post-normalize left shift
	input  wire            i_a4stg_rndadd_cout, // carry out of the round adder
	output exp_t           o_add_exp_out        // final add exponent
);

	exp_wide_t exp_shl;     // exponent less the shift count
	exp_wide_t exp_inc;     // exponent plus the rounding carry
	exp_wide_t exp_pre;     // before clamping
	exp_wide_t prec_max;    // saturation value of this precision
	logic      shl_nz;
	logic      exp_uf;      // result went below zero
	logic      exp_of;      // result reached the precision maximum
	exp_t      exp_out_nxt;

	//////////////////////////////////////////////////////////////////////
	// normalization and rounding
	//////////////////////////////////////////////////////////////////////

	assign shl_nz  = |i_a4stg_shl_cnt;
	assign exp_shl = i_a4stg_exp - exp_wide_t'(i_a4stg_shl_cnt); // borrow lands in bit 12
	assign exp_inc = i_a4stg_exp + exp_wide_t'(1);

	// a left shift means no round carry is possible, so it wins
	always_comb begin
		if (shl_nz) begin
			exp_pre = exp_shl;
		end else if (i_a4stg_rndadd_cout) begin
			exp_pre = exp_inc;
		end else begin
			exp_pre = i_a4stg_exp;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// underflow and overflow clamp
	//////////////////////////////////////////////////////////////////////

	assign prec_max = i_a4stg_dbl ? exp_wide_t'(`FPU_DBL_EXP_MAX)
		: exp_wide_t'(`FPU_SNG_EXP_MAX);

	assign exp_uf = exp_pre[`FPU_EXP_WIDE_W-1];           // sign guard bit
	assign exp_of = !exp_uf && (exp_pre >= prec_max);     // only for positive values

	always_comb begin
		if (exp_uf) begin
			exp_out_nxt = '0;                             // flush to zero
		end else if (exp_of) begin
			exp_out_nxt = prec_max[`FPU_EXP_W-1:0];       // all ones of the precision
		end else begin
			exp_out_nxt = exp_pre[`FPU_EXP_W-1:0];
		end
	end

	//////////////////////////////////////////////////////////////////////
	// output register
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge i_rclk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_add_exp_out <= '0;
		end else if (i_a6stg_step) begin
			o_add_exp_out <= exp_out_nxt;
		end
	end

endmodule

`default_nettype wire

//--- logic/exp_adjust.sv
//////////////////////////////////////////////////////////////////////
// stage 3 and 4 of the exponent path
// normalize adjust by +1 / -1 / 0 into the held stage 4 register
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "fpu_exp_config.svh"

module exp_adjust import fpu_exp_pkg::*, fpu_pipe_pkg::*; (
	input  wire            i_rclk,
	input  wire            i_arst_n,
	input  wire            i_a6stg_step, // advance stages 2 -> 3 -> 4
	input  wire exp_adj_t  i_a3stg_adj,  // adjust code for the stage 3 item
	exp_stage_if.dst       i_stg,        // stage 2 exponent and precision
	output exp_wide_t      o_a4stg_exp,  // stage 4 exponent
	output logic           o_a4stg_dbl   // stage 4 precision
);

	exp_wide_t a3_exp_q;
	logic      a3_dbl_q;
	exp_wide_t a3_exp_plus1;
	exp_wide_t a3_exp_minus1;
	exp_wide_t a4_exp_sel;   // adjusted value picked by the code
	exp_wide_t a4_exp_nxt;
	logic      a4_dbl_nxt;

	//////////////////////////////////////////////////////////////////////
	// stage 3 register
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge i_rclk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			a3_exp_q <= '0;
			a3_dbl_q <= 1'b0;
		end else if (i_a6stg_step) begin
			a3_exp_q <= i_stg.stage2_exp;
			a3_dbl_q <= i_stg.stage2_dbl;
		end
	end

	// both directions computed up front, code only steers the mux
	assign a3_exp_plus1  = a3_exp_q + exp_wide_t'(1);
	assign a3_exp_minus1 = a3_exp_q - exp_wide_t'(1); // 0 wraps negative

	always_comb begin
		case (i_a3stg_adj)
			`FPU_ADJ_INC:  a4_exp_sel = a3_exp_plus1;
			`FPU_ADJ_DEC:  a4_exp_sel = a3_exp_minus1;
			`FPU_ADJ_SAME: a4_exp_sel = a3_exp_q;
			default:       a4_exp_sel = a3_exp_q; // spare code keeps exponent
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// stage 4 register
	//////////////////////////////////////////////////////////////////////

	// no enable here, the register feeds itself back while the pipe stalls
	assign a4_exp_nxt = i_a6stg_step ? a4_exp_sel : o_a4stg_exp;
	assign a4_dbl_nxt = i_a6stg_step ? a3_dbl_q   : o_a4stg_dbl;

	always_ff @(posedge i_rclk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_a4stg_exp <= '0;
			o_a4stg_dbl <= 1'b0;
		end else begin
			o_a4stg_exp <= a4_exp_nxt;
			o_a4stg_dbl <= a4_dbl_nxt;
		end
	end

endmodule

`default_nettype wire

//--- logic/exp_compare.sv
//////////////////////////////////////////////////////////////////////
// stage 1 and 2 of the exponent path
// operand capture, exponent compare and larger exponent register
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "fpu_exp_config.svh"

module exp_compare import fpu_exp_pkg::*; (
	input  wire       i_rclk,
	input  wire       i_arst_n,
	input  wire       i_a1stg_step,  // load the operand registers
	input  wire       i_a6stg_step,  // advance into stage 2
	input  wire exp_t i_in1_exp,     // operand 1 exponent field
	input  wire exp_t i_in2_exp,     // operand 2 exponent field
	input  wire       i_dblop,       // 1 = double precision
	output exp_diff_t o_exp_diff,    // in1 - in2, low bits
	output logic      o_in2_larger,  // borrow out of the compare
	exp_stage_if.src  o_stg          // stage 2 register outputs
);

	exp_t      in1_q;      // stage 1 operand 1
	exp_t      in2_q;      // stage 1 operand 2
	logic      dbl_q;      // stage 1 precision
	exp_wide_t in1_fld;    // precision field of operand 1
	exp_wide_t in2_fld;
	exp_wide_t exp_diff;   // full difference incl. borrow bit
	exp_wide_t larger_fld;

	//////////////////////////////////////////////////////////////////////
	// stage 1 operand registers
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge i_rclk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			in1_q <= '0;
			in2_q <= '0;
			dbl_q <= 1'b0;
		end else if (i_a1stg_step) begin
			in1_q <= i_in1_exp;
			in2_q <= i_in2_exp;
			dbl_q <= i_dblop;
		end
	end

	// single precision only looks at the top bits of the raw field
	assign in1_fld = dbl_q ? exp_wide_t'(in1_q)
		: exp_wide_t'(in1_q[`FPU_EXP_W-1 -: `FPU_SNG_EXP_W]);
	assign in2_fld = dbl_q ? exp_wide_t'(in2_q)
		: exp_wide_t'(in2_q[`FPU_EXP_W-1 -: `FPU_SNG_EXP_W]);

	//////////////////////////////////////////////////////////////////////
	// exponent compare
	//////////////////////////////////////////////////////////////////////

	// both fields are zero extended so bit 12 is a clean borrow
	assign exp_diff = in1_fld - in2_fld;

	assign o_exp_diff   = exp_diff[`FPU_DIFF_W-1:0];      // alignment amount
	assign o_in2_larger = exp_diff[`FPU_EXP_WIDE_W-1];    // set when in2 > in1

	assign larger_fld = o_in2_larger ? in2_fld : in1_fld; // ties go to in1

	//////////////////////////////////////////////////////////////////////
	// stage 2 register
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge i_rclk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_stg.stage2_exp <= '0;
			o_stg.stage2_dbl <= 1'b0;
		end else if (i_a6stg_step) begin
			o_stg.stage2_exp <= larger_fld;
			o_stg.stage2_dbl <= dbl_q;     // precision follows the item
		end
	end

endmodule

`default_nettype wire

//--- logic/exp_stage_if.sv
//////////////////////////////////////////////////////////////////////
// stage 2 boundary of the exponent path
// compare side drives it, adjust side picks it up
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

interface exp_stage_if import fpu_exp_pkg::*; ();

	exp_wide_t stage2_exp; // larger exponent, zero extended
	logic      stage2_dbl; // precision flag travelling with it

	//////////////////////////////////////////////////////////////////////
	// views
	//////////////////////////////////////////////////////////////////////

	modport src (
		output stage2_exp,
		output stage2_dbl
	);

	modport dst (
		input  stage2_exp,
		input  stage2_dbl
	);

endinterface

`default_nettype wire

//--- logic/fpu_pipe_pkg.sv
//////////////////////////////////////////////////////////////////////
// pipeline control types driven from the fraction path
//////////////////////////////////////////////////////////////////////

`default_nettype none

`include "fpu_exp_config.svh"

package fpu_pipe_pkg;

	// normalize adjust code, see FPU_ADJ_* in the config header
	typedef logic [1:0] exp_adj_t;

	// left shift count after normalization
	typedef logic [`FPU_SHL_CNT_W-1:0] shl_cnt_t;

endpackage

`default_nettype wire

//--- logic/fpu_exp_pkg.sv
//////////////////////////////////////////////////////////////////////
// exponent data types of the add pipe
// imported by every block that moves or computes an exponent
//////////////////////////////////////////////////////////////////////

`default_nettype none

`include "fpu_exp_config.svh"

package fpu_exp_pkg;

	// raw field from the operand, also the width of the final result
	typedef logic [`FPU_EXP_W-1:0] exp_t;

	// internal exponent
	// top bit set means the value went negative (borrow out)
	typedef logic [`FPU_EXP_WIDE_W-1:0] exp_wide_t;

	// alignment difference as seen by the fraction path
	typedef logic [`FPU_DIFF_W-1:0] exp_diff_t;

endpackage

`default_nettype wire

//--- include/fpu_exp_config.svh
//////////////////////////////////////////////////////////////////////
// widths, exponent maxima and adjust codes of the add exponent path
// include wherever a width or a constant of the datapath is needed
//////////////////////////////////////////////////////////////////////

`ifndef FPU_EXP_CONFIG_SVH
`define FPU_EXP_CONFIG_SVH

//////////////////////////////////////////////////////////////////////
// field and datapath widths
//////////////////////////////////////////////////////////////////////

`define FPU_EXP_W       11 // raw exponent field of a double operand
`define FPU_SNG_EXP_W   8  // single field sits in the top bits of the raw field
`define FPU_EXP_WIDE_W  13 // internal width with carry and borrow guard bits
`define FPU_DIFF_W      12 // exposed exponent difference
`define FPU_SHL_CNT_W   6  // post-normalization left shift count

// largest exponent per precision, used for overflow saturation
`define FPU_DBL_EXP_MAX 11'h7ff
`define FPU_SNG_EXP_MAX 11'h0ff

//////////////////////////////////////////////////////////////////////
// stage 3 normalize adjust codes
//////////////////////////////////////////////////////////////////////

`define FPU_ADJ_SAME    2'd0 // keep exponent
`define FPU_ADJ_INC     2'd1 // fraction carried out
`define FPU_ADJ_DEC     2'd2 // fraction one place short

`endif
